//--- design/cam_link_pkg.sv
package cam_link_pkg;

    // serial word on the wire, oldest bit first:
    //   start | d9 d8 ... d0 | stop
    // one bit per clk on each lane

    // bits per link word, start and stop included
    localparam int word_bits = 12;

    // payload bits between start and stop
    localparam int data_bits = 10;

    // framing bit values
    localparam logic start_val = 1'b1;
    localparam logic stop_val  = 1'b0;

    // positions inside the receive shift register once a whole word is in
    // the oldest bit sits at the top, the newest at bit zero
    localparam int start_pos = word_bits - 1;
    localparam int stop_pos  = 0;

    // the data field sits between the two framing bits, msb first
    localparam int data_lsb = stop_pos + 1;
    localparam int data_msb = data_lsb + data_bits - 1;

endpackage

//--- design/cam_rx_top.sv
`timescale 1ns/1ns

module cam_rx_top #(
    parameter int               WIDTH      = 2,
    parameter logic [WIDTH-1:0] SWAP       = '0,
    parameter int               GOOD_WORDS = 8,
    parameter int               RDY_BITS   = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [WIDTH-1:0]      in_bit,
    output logic [WIDTH*10-1:0]   px,
    output logic [WIDTH-1:0]      line_valid,
    output logic [WIDTH-1:0]      frame_valid,
    output logic [WIDTH-1:0]      train_done,
    output logic [WIDTH*8-1:0]    skew_cnt,
    output logic [WIDTH*8-1:0]    err_cnt,
    output logic                  rdy
);

    localparam int px_w = $bits(cam_video_pkg::video_word_t);  // bits per lane on px

    logic [RDY_BITS-1:0] rdy_cnt;
    logic                all_trained;

    for (genvar j = 0; j < WIDTH; j++) begin : g_lane
        logic       word_valid;
        logic [9:0] word_data;
        logic       dec_rst;

        // decoder restarts whenever its lane loses alignment
        assign dec_rst = rst | ~train_done[j];

        cam_word_align #(
            .SWAP_BIT   (SWAP[j]),
            .GOOD_WORDS (GOOD_WORDS)
        ) i_cam_word_align (
            .clk          (clk),
            .rst          (rst),
            .in_bit       (in_bit[j]),
            .inhibit_slip (frame_valid[j]),     // no slipping mid frame
            .word_valid   (word_valid),
            .word_data    (word_data),
            .train_done   (train_done[j]),
            .skew_cnt     (skew_cnt[j*8 +: 8]),
            .err_cnt      (err_cnt[j*8 +: 8])
        );

        cam_sync_decode i_cam_sync_decode (
            .clk         (clk),
            .rst         (dec_rst),
            .word_valid  (word_valid),
            .word_data   (word_data),
            .px          (px[j*px_w +: px_w]),
            .line_valid  (line_valid[j]),
            .frame_valid (frame_valid[j])
        );
    end

    assign all_trained = &train_done;

    // holdoff before declaring the link usable
    always_ff @(posedge clk) begin
        if (rst) begin
            rdy_cnt <= '0;
        end else if (!all_trained) begin
            rdy_cnt <= '0;              // any lane drop restarts it
        end else if (!rdy) begin
            rdy_cnt <= rdy_cnt + 1'b1;  // stops at all ones
        end
    end

    assign rdy = &rdy_cnt;

endmodule

//--- design/cam_sync_decode.sv
`timescale 1ns/1ns

module cam_sync_decode (
    input  logic       clk,
    input  logic       rst,
    input  logic       word_valid,
    input  logic [9:0] word_data,
    output logic [9:0] px,
    output logic       line_valid,
    output logic       frame_valid
);

    cam_video_pkg::video_word_t word;
    logic                       is_sync;
    logic                       line_open;  // between line start and line end

    assign word    = word_data;
    assign is_sync = (word.sync.prefix == cam_video_pkg::sync_prefix);

    always_ff @(posedge clk) begin
        if (rst) begin
            px          <= '0;
            line_valid  <= 1'b0;
            frame_valid <= 1'b0;
            line_open   <= 1'b0;
        end else begin
            line_valid <= 1'b0;     // one pulse per pixel
            if (word_valid) begin
                if (is_sync) begin
                    case (word.sync.code)
                        cam_video_pkg::code_fs: begin
                            frame_valid <= 1'b1;
                        end
                        cam_video_pkg::code_fe: begin
                            frame_valid <= 1'b0;
                            line_open   <= 1'b0;    // a dangling line ends with the frame
                        end
                        cam_video_pkg::code_ls: begin
                            if (frame_valid) begin
                                line_open <= 1'b1;
                            end
                        end
                        cam_video_pkg::code_le: begin
                            line_open <= 1'b0;
                        end
                        default: begin
                            // reserved codes carry nothing for us
                        end
                    endcase
                end else if (line_open) begin
                    px         <= word.pix;
                    line_valid <= 1'b1;
                end
                // pixels outside a line are blanking filler, dropped
            end
        end
    end

    // lines only ever open inside a frame
    a_line_in_frame: assert property (@(posedge clk) disable iff (rst)
        line_valid |-> frame_valid);

    // sync words must never leak out as pixels
    a_px_range: assert property (@(posedge clk) disable iff (rst)
        line_valid |-> (px <= cam_video_pkg::pix_max));

endmodule

//--- design/cam_video_pkg.sv
package cam_video_pkg;

    // sync view of a ten-bit word
    typedef struct packed {
        logic [5:0] prefix;     // all ones marks a sync word
        logic [3:0] code;       // which sync event
    } sync_word_t;

    // the same ten bits read either as a pixel or as a sync word
    typedef union packed {
        logic [9:0] pix;
        sync_word_t sync;
    } video_word_t;

    // 0x3f0..0x3ff are reserved for sync
    localparam logic [5:0] sync_prefix = 6'h3f;

    // sync codes carried in the low nibble
    localparam logic [3:0] code_fs = 4'd1;  // frame start
    localparam logic [3:0] code_fe = 4'd2;  // frame end
    localparam logic [3:0] code_ls = 4'd3;  // line start
    localparam logic [3:0] code_le = 4'd4;  // line end

    // largest legal pixel value, everything above collides with sync
    localparam logic [9:0] pix_max = 10'h3ef;

endpackage

//--- design/cam_word_align.sv
`timescale 1ns/1ns

module cam_word_align #(
    parameter bit SWAP_BIT   = 1'b0,
    parameter int GOOD_WORDS = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_bit,
    input  logic       inhibit_slip,
    output logic       word_valid,
    output logic [9:0] word_data,
    output logic       train_done,
    output logic [7:0] skew_cnt,
    output logic [7:0] err_cnt
);

    // one spare bit so the slip value never looks like a boundary
    localparam int cnt_w = $clog2(cam_link_pkg::word_bits) + 1;
    localparam int run_w = $clog2(GOOD_WORDS + 1);

    logic [cam_link_pkg::word_bits-1:0] shift_reg;
    logic [cnt_w-1:0]                   bit_cnt;
    logic [run_w-1:0]                   run_cnt;
    logic                               rx_bit;
    logic                               boundary;
    logic                               framed_ok;

    assign rx_bit = in_bit ^ SWAP_BIT;  // undo board level p/n swap

    // bit_cnt at word_bits-1 means a full word sits in shift_reg
    assign boundary = (bit_cnt == cnt_w'(cam_link_pkg::word_bits - 1));

    assign framed_ok = (shift_reg[cam_link_pkg::start_pos] == cam_link_pkg::start_val) &&
                       (shift_reg[cam_link_pkg::stop_pos] == cam_link_pkg::stop_val);

    // newest bit enters at the bottom
    always_ff @(posedge clk) begin
        shift_reg <= {shift_reg[cam_link_pkg::word_bits-2:0], rx_bit};
    end

    always_ff @(posedge clk) begin
        if (boundary) begin
            word_data <= shift_reg[cam_link_pkg::data_msb:cam_link_pkg::data_lsb];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            run_cnt    <= '0;
            word_valid <= 1'b0;
            train_done <= 1'b0;
            skew_cnt   <= '0;
            err_cnt    <= '0;
        end else begin
            word_valid <= 1'b0;
            if (!boundary) begin
                bit_cnt <= bit_cnt + 1'b1;
            end else if (framed_ok) begin
                bit_cnt    <= '0;
                word_valid <= 1'b1;
                if (run_cnt != run_w'(GOOD_WORDS)) begin
                    run_cnt <= run_cnt + 1'b1;
                end
                if (run_cnt >= run_w'(GOOD_WORDS - 1)) begin
                    train_done <= 1'b1;     // enough clean words in a row
                end
            end else if (inhibit_slip) begin
                // inside a frame, keep alignment and just count the hit
                bit_cnt <= '0;
                if (err_cnt != 8'hff) begin
                    err_cnt <= err_cnt + 8'd1;
                end
            end else begin
                // all ones wraps to zero, so the next boundary comes one bit late
                bit_cnt    <= '1;
                skew_cnt   <= skew_cnt + 8'd1;  // free running, wraps
                run_cnt    <= '0;
                train_done <= 1'b0;
            end
        end
    end

    // words are twelve bits apart, strobes never touch
    a_valid_spacing: assert property (@(posedge clk) disable iff (rst)
        word_valid |=> !word_valid);

    // decoder frame_valid freezes the boundary search
    a_no_slip_in_frame: assert property (@(posedge clk) disable iff (rst)
        inhibit_slip |=> $stable(skew_cnt));

endmodule

//--- dv/cam_lane_model.sv
`timescale 1ns/1ns

module cam_lane_model #(
    parameter bit INVERT = 1'b0     // lane wired with p and n crossed
) (
    input  logic clk,
    input  int   offset,            // idle bits before the first word
    output logic ser
);

    logic [cam_link_pkg::word_bits-1:0] word_q[$];  // framed words waiting to go out
    logic [9:0]                         exp_q[$];   // pixels the receiver still owes
    bit                                 add_bit  = 1'b0;
    bit                                 in_frame = 1'b0;
    bit                                 in_line  = 1'b0;

    // queue one word, a bad one goes out with its stop bit flipped
    task automatic push_word(input logic [9:0] data, input bit bad);
        if (bad) begin
            word_q.push_back({cam_link_pkg::start_val, data, ~cam_link_pkg::stop_val});
        end else begin
            if (data[9:4] == cam_video_pkg::sync_prefix) begin
                if (data[3:0] == cam_video_pkg::code_fs) begin
                    in_frame = 1'b1;
                end else if (data[3:0] == cam_video_pkg::code_fe) begin
                    in_frame = 1'b0;
                    in_line  = 1'b0;
                end else if (data[3:0] == cam_video_pkg::code_ls && in_frame) begin
                    in_line = 1'b1;
                end else if (data[3:0] == cam_video_pkg::code_le) begin
                    in_line = 1'b0;
                end
            end else if (in_line) begin
                exp_q.push_back(data);  // only line pixels come back out
            end
            word_q.push_back({cam_link_pkg::start_val, data, cam_link_pkg::stop_val});
        end
    endtask

    // one extra low bit before the next word
    task automatic insert_bit();
        add_bit = 1'b1;
    endtask

    initial begin
        logic [cam_link_pkg::word_bits-1:0] cur;
        ser = INVERT;       // line idles low
        @(negedge clk);
        for (int i = 0; i < offset; i++) begin
            @(negedge clk);
        end
        forever begin
            if (add_bit) begin
                add_bit = 1'b0;
                ser     = INVERT;
                @(negedge clk);
            end
            if (word_q.size() != 0) begin
                cur = word_q.pop_front();
            end else begin
                // blanking filler, a zero pixel outside any line
                cur = {cam_link_pkg::start_val, 10'h000, cam_link_pkg::stop_val};
            end
            for (int b = cam_link_pkg::word_bits - 1; b >= 0; b--) begin
                ser = cur[b] ^ INVERT;      // oldest bit first
                @(negedge clk);
            end
        end
    end

endmodule

//--- dv/cam_rx_tb.sv
`timescale 1ns/1ns

module cam_rx_tb;

    localparam int rdy_bits = 6;
    localparam int rdy_hold = (1 << rdy_bits) - 1;

    logic        clk;
    logic        rst;
    logic [1:0]  in_bit;
    logic [19:0] px;
    logic [1:0]  line_valid;
    logic [1:0]  frame_valid;
    logic [1:0]  train_done;
    logic [15:0] skew_cnt;
    logic [15:0] err_cnt;
    logic        rdy;

    int          offset [2];
    bit          expect_trained = 1'b0;
    bit          expect_rdy     = 1'b0;
    logic [7:0]  err_before [2];
    logic [7:0]  skew_before [2];

    cam_rx_top #(
        .WIDTH    (2),
        .SWAP     (2'b10),
        .RDY_BITS (rdy_bits)
    ) i_cam_rx_top (
        .clk         (clk),
        .rst         (rst),
        .in_bit      (in_bit),
        .px          (px),
        .line_valid  (line_valid),
        .frame_valid (frame_valid),
        .train_done  (train_done),
        .skew_cnt    (skew_cnt),
        .err_cnt     (err_cnt),
        .rdy         (rdy)
    );

    cam_lane_model #(.INVERT(1'b0)) i_lane_model_0 (
        .clk (clk), .offset (offset[0]), .ser (in_bit[0])
    );

    cam_lane_model #(.INVERT(1'b1)) i_lane_model_1 (    // pairs with SWAP bit 1
        .clk (clk), .offset (offset[1]), .ser (in_bit[1])
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic lane_push(input int lane, input logic [9:0] data, input bit bad);
        if (lane == 0) begin
            i_lane_model_0.push_word(data, bad);
        end else begin
            i_lane_model_1.push_word(data, bad);
        end
    endtask

    function automatic int pending(input int lane);
        if (lane == 0) begin
            pending = i_lane_model_0.exp_q.size();
        end else begin
            pending = i_lane_model_1.exp_q.size();
        end
    endfunction

    function automatic logic [9:0] pop_expected(input int lane);
        if (lane == 0) begin
            pop_expected = i_lane_model_0.exp_q.pop_front();
        end else begin
            pop_expected = i_lane_model_1.exp_q.pop_front();
        end
    endfunction

    function automatic logic [9:0] sync_word(input logic [3:0] code);
        sync_word = {cam_video_pkg::sync_prefix, code};
    endfunction

    function automatic logic [9:0] rand_pixel();
        rand_pixel = 10'($urandom_range(32'(cam_video_pkg::pix_max)));
    endfunction

    // per cycle checks on the decoded outputs
    always @(negedge clk) begin
        logic [9:0] exp_px;
        if (!rst) begin
            for (int j = 0; j < 2; j++) begin
                assert (!line_valid[j] || frame_valid[j]) else
                    abort_run($sformatf("lane %0d line_valid high outside a frame", j));
                if (line_valid[j]) begin
                    assert (pending(j) > 0) else
                        abort_run($sformatf("lane %0d put out a pixel never sent in a line", j));
                    exp_px = pop_expected(j);
                    assert (px[j*10 +: 10] == exp_px) else
                        abort_run($sformatf("error px lane %0d: got 0x%03h, expected 0x%03h",
                                            j, px[j*10 +: 10], exp_px));
                end
            end
            if (expect_trained) begin
                assert (train_done == 2'b11) else
                    abort_run($sformatf("error train_done: got 0x%h, expected 0x3", train_done));
            end
            if (expect_rdy) begin
                assert (rdy) else abort_run("error rdy: got 0x0, expected 0x1");
            end
        end
    end

    task automatic wait_trained(input int limit);
        int n;
        n = 0;
        while (train_done != 2'b11) begin
            assert (!rdy) else abort_run("rdy is high while a lane is untrained");
            assert (n < limit) else abort_run("timeout waiting for both lanes to train");
            @(negedge clk);
            n++;
        end
    endtask

    // starts on the first cycle with both lanes trained
    task automatic check_holdoff();
        int n;
        n = 0;
        while (!rdy) begin
            assert (train_done == 2'b11) else abort_run("a lane lost training during holdoff");
            assert (n <= rdy_hold) else abort_run("timeout waiting for rdy");
            @(negedge clk);
            n++;
        end
        assert (n == rdy_hold) else
            abort_run($sformatf("error rdy holdoff: got 0x%0h cycles, expected 0x%0h",
                                n, rdy_hold));
    endtask

    task automatic wait_frame(input int lane, input logic level, input int limit);
        int n;
        n = 0;
        while (frame_valid[lane] != level) begin
            assert (n < limit) else
                abort_run($sformatf("timeout waiting for frame_valid[%0d] to be %0d",
                                    lane, level));
            @(negedge clk);
            n++;
        end
    endtask

    // blanking pixels before and after lines are sent but never expected
    task automatic queue_frame(input int nlines, input int npix, input bit corrupt);
        for (int j = 0; j < 2; j++) begin
            lane_push(j, sync_word(cam_video_pkg::code_fs), 1'b0);
            lane_push(j, rand_pixel(), 1'b0);
            for (int l = 0; l < nlines; l++) begin
                lane_push(j, sync_word(cam_video_pkg::code_ls), 1'b0);
                for (int p = 0; p < npix; p++) begin
                    lane_push(j, rand_pixel(), corrupt && l == 0 && p == npix / 2);
                end
                lane_push(j, sync_word(cam_video_pkg::code_le), 1'b0);
                lane_push(j, rand_pixel(), 1'b0);
            end
            lane_push(j, sync_word(cam_video_pkg::code_fe), 1'b0);
        end
    endtask

    task automatic run_frame(input int nlines, input int npix, input bit corrupt);
        int words;
        words = 3 + nlines * (npix + 3);
        assert (frame_valid == 2'b00) else
            abort_run($sformatf("error frame_valid: got 0x%h, expected 0x0", frame_valid));
        queue_frame(nlines, npix, corrupt);
        for (int j = 0; j < 2; j++) begin
            wait_frame(j, 1'b1, 4 * cam_link_pkg::word_bits);
        end
        for (int j = 0; j < 2; j++) begin
            wait_frame(j, 1'b0, (words + 4) * cam_link_pkg::word_bits);
            assert (pending(j) == 0) else
                abort_run($sformatf("lane %0d lost %0d line pixels", j, pending(j)));
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h96a072cb));
        offset[0] = int'($urandom_range(11));
        offset[1] = int'($urandom_range(11));
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        wait_trained(800);
        for (int j = 0; j < 2; j++) begin
            assert (skew_cnt[j*8 +: 8] < 8'd12) else
                abort_run($sformatf("error skew_cnt lane %0d: got 0x%02h, expected below 0x0c",
                                    j, skew_cnt[j*8 +: 8]));
        end
        check_holdoff();
        expect_trained = 1'b1;
        expect_rdy     = 1'b1;

        run_frame(3, 16, 1'b0);
        run_frame(2, 8, 1'b0);

        // bad stop bit mid line on both lanes
        for (int j = 0; j < 2; j++) begin
            err_before[j]  = err_cnt[j*8 +: 8];
            skew_before[j] = skew_cnt[j*8 +: 8];
        end
        run_frame(2, 12, 1'b1);
        for (int j = 0; j < 2; j++) begin
            assert (err_cnt[j*8 +: 8] == err_before[j] + 8'd1) else
                abort_run($sformatf("error err_cnt lane %0d: got 0x%02h, expected 0x%02h",
                                    j, err_cnt[j*8 +: 8], err_before[j] + 8'd1));
            assert (skew_cnt[j*8 +: 8] == skew_before[j]) else
                abort_run($sformatf("error skew_cnt lane %0d: got 0x%02h, expected 0x%02h",
                                    j, skew_cnt[j*8 +: 8], skew_before[j]));
        end

        // lane 0 slips one bit between frames
        expect_trained = 1'b0;
        expect_rdy     = 1'b0;
        skew_before[0] = skew_cnt[7:0];
        skew_before[1] = skew_cnt[15:8];
        i_lane_model_0.insert_bit();
        n = 0;
        while (train_done[0]) begin
            assert (n < 4 * cam_link_pkg::word_bits) else
                abort_run("timeout waiting for lane 0 to drop training");
            @(negedge clk);
            n++;
        end
        assert (rdy) else abort_run("error rdy: got 0x0, expected 0x1");
        @(negedge clk);
        assert (!rdy) else abort_run("error rdy: got 0x1, expected 0x0");
        wait_trained(800);
        assert (skew_cnt[7:0] == skew_before[0] + 8'd1) else
            abort_run($sformatf("error skew_cnt lane 0: got 0x%02h, expected 0x%02h",
                                skew_cnt[7:0], skew_before[0] + 8'd1));
        assert (skew_cnt[15:8] == skew_before[1]) else
            abort_run($sformatf("error skew_cnt lane 1: got 0x%02h, expected 0x%02h",
                                skew_cnt[15:8], skew_before[1]));
        check_holdoff();
        expect_trained = 1'b1;
        expect_rdy     = 1'b1;
        run_frame(1, 8, 1'b0);

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- list.f
design/cam_link_pkg.sv
design/cam_video_pkg.sv
design/cam_word_align.sv
design/cam_sync_decode.sv
design/cam_rx_top.sv
dv/cam_lane_model.sv
dv/cam_rx_tb.sv

//--- run.sh
#!/bin/sh
# build and run the camera link receiver testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cam_rx_tb \
    -f list.f

out=$(./obj_dir/Vcam_rx_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
    exit 0
else
    exit 1
fi
